// File: common/a23_bus_pkg.sv
// ==================================================
// shared bus definitions
// AXI4 channel payload structs
// SRAM port request struct
// FSM state enums and burst type
// cache line length
// ==================================================
package a23_bus_pkg;

	// beats in a cache line fill
	localparam int LINE_WORDS = 4;

	// AXI burst type encoding, only INCR and WRAP are issued
	typedef enum logic [1:0] {
		BURST_INCR = 2'b01,
		BURST_WRAP = 2'b10
	} burst_e;

	// ==================================================
	// AXI channel payloads
	// ==================================================
	typedef struct packed {
		logic [31:0] araddr;
		logic [7:0]  arlen;
		burst_e      arburst;
		logic [2:0]  arsize;
	} axi_ar_t;

	// write bursts are always single beat INCR
	typedef struct packed {
		logic [31:0] awaddr;
		logic [7:0]  awlen;
		logic [2:0]  awsize;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wlast;
	} axi_w_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        rlast;
	} axi_r_t;

	typedef struct packed {
		logic [1:0] bresp;
	} axi_b_t;

	// single SRAM port request, word addressed
	typedef struct packed {
		logic [31:0] addr;
		logic        we;
		logic [3:0]  be;
		logic [31:0] wdata;
	} mem_req_t;

	// ==================================================
	// state encodings
	// ==================================================
	typedef enum logic [2:0] {RD_IDLE, RD_CORE_AR, RD_CORE_R, RD_LINE_AR, RD_LINE_R} rd_state_e;
	typedef enum logic [1:0] {WR_IDLE, WR_AW, WR_W, WR_B} wr_state_e;
	typedef enum logic [1:0] {SRD_IDLE, SRD_MEM, SRD_BEAT} srd_state_e;
	typedef enum logic [1:0] {SWR_IDLE, SWR_DATA, SWR_MEM, SWR_RESP} swr_state_e;

endpackage

// File: hw/axi_master/a23_axi_master.sv
`timescale 1ns/10ps
// ==================================================
// AXI4 master for core and cache accesses
// read FSM: single core reads, 4-beat wrap fills
// write FSM: drains a one-entry posted write buffer
// read-after-write stall on the buffered address
// ==================================================
module a23_axi_master
	import a23_bus_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	// core and cache requests
	input  logic        i_select,
	input  logic        i_cache_req,
	input  logic        i_write_enable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_write_data,
	input  logic [3:0]  i_byte_enable,
	output logic        o_stall,
	output logic        o_stall_cache,
	output logic [31:0] o_read_data,
	output logic        o_read_valid,
	// AXI4 master side
	output axi_ar_t     o_ar,
	output logic        o_arvalid,
	input  logic        i_arready,
	input  axi_r_t      i_r,
	input  logic        i_rvalid,
	output logic        o_rready,
	output axi_aw_t     o_aw,
	output logic        o_awvalid,
	input  logic        i_awready,
	output axi_w_t      o_w,
	output logic        o_wvalid,
	input  logic        i_wready,
	input  axi_b_t      i_b,
	input  logic        i_bvalid,
	output logic        o_bready
);
	// lowest address bit above the line offset
	localparam int LINE_LSB = $clog2(LINE_WORDS) + 2;

	logic        core_rd;
	logic        core_wr;
	logic        cache_rd;
	logic        cache_wr;
	rd_state_e   rd_state;
	wr_state_e   wr_state;
	logic [31:0] ar_addr;
	logic [31:0] wbuf_addr;
	logic [31:0] wbuf_data;
	logic [3:0]  wbuf_be;
	logic        wbuf_busy;
	logic        wr_take;
	logic        raw_word;
	logic        raw_line;
	logic        core_rd_done;
	logic        line_rd_done;

	// request decode, address and data lines are shared by core and cache
	assign core_rd  = i_select & ~i_write_enable;
	assign core_wr  = i_select & i_write_enable;
	assign cache_rd = i_cache_req & ~i_write_enable;
	assign cache_wr = i_cache_req & i_write_enable;

	// buffer stays occupied until its B beat is taken
	assign wbuf_busy = (wr_state != WR_IDLE);
	assign wr_take   = (core_wr | cache_wr) & ~wbuf_busy;

	// a fill must not overtake a pending write anywhere in its line
	assign raw_word = wbuf_busy & (i_address[31:2] == wbuf_addr[31:2]);
	assign raw_line = wbuf_busy & (i_address[31:LINE_LSB] == wbuf_addr[31:LINE_LSB]);

	assign core_rd_done = (rd_state == RD_CORE_R) & i_rvalid & i_r.rlast;
	assign line_rd_done = (rd_state == RD_LINE_R) & i_rvalid & i_r.rlast;

	assign o_stall       = (core_rd & ~core_rd_done) | (core_wr & wbuf_busy);
	assign o_stall_cache = (cache_rd & ~line_rd_done) | (cache_wr & wbuf_busy);

	// ==================================================
	// read side
	// ==================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					// cache fill wins over a core read
					if (cache_rd) begin
						if (!raw_line)
							rd_state <= RD_LINE_AR;
					end else if (core_rd && !raw_word) begin
						rd_state <= RD_CORE_AR;
					end
				end
				RD_CORE_AR: if (i_arready) rd_state <= RD_CORE_R;
				RD_CORE_R:  if (core_rd_done) rd_state <= RD_IDLE;
				RD_LINE_AR: if (i_arready) rd_state <= RD_LINE_R;
				RD_LINE_R:  if (line_rd_done) rd_state <= RD_IDLE;
				default:    rd_state <= RD_IDLE;
			endcase
		end
	end

	// address tracks the request while idle and freezes once AR is up
	always_ff @(posedge i_clk) begin
		if (rd_state == RD_IDLE)
			ar_addr <= {i_address[31:2], 2'b00};
	end

	assign o_arvalid     = (rd_state == RD_CORE_AR) | (rd_state == RD_LINE_AR);
	assign o_ar.araddr   = ar_addr;
	assign o_ar.arlen    = (rd_state == RD_LINE_AR) ? 8'(LINE_WORDS - 1) : 8'd0;
	assign o_ar.arburst  = (rd_state == RD_LINE_AR) ? BURST_WRAP : BURST_INCR;
	assign o_ar.arsize   = 3'd2;
	assign o_rready      = (rd_state == RD_CORE_R) | (rd_state == RD_LINE_R);
	// every accepted R beat goes straight to the requester
	assign o_read_valid  = o_rready & i_rvalid;
	assign o_read_data   = i_r.rdata;

	// ==================================================
	// write side
	// ==================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: if (wr_take) wr_state <= WR_AW;
				WR_AW:   if (i_awready) wr_state <= WR_W;
				WR_W:    if (i_wready) wr_state <= WR_B;
				WR_B: begin
					// an error response resends the buffered write
					if (i_bvalid)
						wr_state <= i_b.bresp[1] ? WR_AW : WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// write-back lines always carry full words
	always_ff @(posedge i_clk) begin
		if (wr_take) begin
			wbuf_addr <= {i_address[31:2], 2'b00};
			wbuf_data <= i_write_data;
			wbuf_be   <= cache_wr ? 4'hf : i_byte_enable;
		end
	end

	assign o_awvalid    = (wr_state == WR_AW);
	assign o_aw.awaddr  = wbuf_addr;
	assign o_aw.awlen   = 8'd0;
	assign o_aw.awsize  = 3'd2;
	assign o_wvalid     = (wr_state == WR_W);
	assign o_w.wdata    = wbuf_data;
	assign o_w.wstrb    = wbuf_be;
	assign o_w.wlast    = 1'b1;
	assign o_bready     = (wr_state == WR_B);

endmodule

// File: hw/axi_sram/axi_sram_rd.sv
`timescale 1ns/10ps
// ==================================================
// SRAM slave read engine
// AR accept, INCR/WRAP address stepping
// one memory read per R beat
// ==================================================
module axi_sram_rd
	import a23_bus_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  axi_ar_t     i_ar,
	input  logic        i_arvalid,
	output logic        o_arready,
	output axi_r_t      o_r,
	output logic        o_rvalid,
	input  logic        i_rready,
	output mem_req_t    o_mem_req,
	output logic        o_mem_req_valid,
	input  logic        i_mem_grant,
	input  logic [31:0] i_mem_rdata
);
	localparam int AW = $clog2(MEM_WORDS);

	srd_state_e    state;
	logic          rd_wait;
	logic [7:0]    beat_cnt;
	logic [7:0]    len;
	burst_e        burst;
	logic [AW-1:0] word;
	logic [AW-1:0] wrap_mask;
	logic [AW-1:0] word_next;
	logic [31:0]   rdata;

	// wrap length is a power of two, so arlen doubles as the index mask
	assign wrap_mask = AW'(len);
	assign word_next = (burst == BURST_WRAP) ?
		((word & ~wrap_mask) | ((word + 1'b1) & wrap_mask)) : (word + 1'b1);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state    <= SRD_IDLE;
			rd_wait  <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				SRD_IDLE: begin
					if (i_arvalid) begin
						state    <= SRD_MEM;
						beat_cnt <= '0;
					end
				end
				SRD_MEM: begin
					// grant cycle, then one cycle for the registered read
					if (rd_wait) begin
						rd_wait <= 1'b0;
						state   <= SRD_BEAT;
					end else if (i_mem_grant) begin
						rd_wait <= 1'b1;
					end
				end
				SRD_BEAT: begin
					if (i_rready) begin
						if (o_r.rlast) begin
							state <= SRD_IDLE;
						end else begin
							beat_cnt <= beat_cnt + 8'd1;
							state    <= SRD_MEM;
						end
					end
				end
				default: state <= SRD_IDLE;
			endcase
		end
	end

	// burst payload and captured read word
	always_ff @(posedge i_clk) begin
		if (state == SRD_IDLE && i_arvalid) begin
			word  <= i_ar.araddr[AW+1:2];
			len   <= i_ar.arlen;
			burst <= i_ar.arburst;
		end else if (state == SRD_BEAT && i_rready) begin
			word <= word_next;
		end
		if (state == SRD_MEM && rd_wait)
			rdata <= i_mem_rdata;
	end

	assign o_arready = (state == SRD_IDLE);
	assign o_rvalid  = (state == SRD_BEAT);
	assign o_r.rdata = rdata;
	assign o_r.rlast = (beat_cnt == len);

	assign o_mem_req_valid = (state == SRD_MEM) & ~rd_wait;
	assign o_mem_req.addr  = 32'(word);
	assign o_mem_req.we    = 1'b0;
	assign o_mem_req.be    = 4'h0;
	assign o_mem_req.wdata = '0;

endmodule

// File: hw/axi_sram/axi_sram_wr.sv
`timescale 1ns/10ps
// ==================================================
// SRAM slave write engine
// AW then W accept, strobed memory write, B reply
// ==================================================
module axi_sram_wr
	import a23_bus_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  logic     i_clk,
	input  logic     i_arst_n,
	input  axi_aw_t  i_aw,
	input  logic     i_awvalid,
	output logic     o_awready,
	input  axi_w_t   i_w,
	input  logic     i_wvalid,
	output logic     o_wready,
	output axi_b_t   o_b,
	output logic     o_bvalid,
	input  logic     i_bready,
	output mem_req_t o_mem_req,
	output logic     o_mem_req_valid,
	input  logic     i_mem_grant
);
	localparam int AW = $clog2(MEM_WORDS);

	swr_state_e    state;
	logic [AW-1:0] word;
	logic [31:0]   wdata;
	logic [3:0]    wstrb;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= SWR_IDLE;
		end else begin
			case (state)
				SWR_IDLE: if (i_awvalid) state <= SWR_DATA;
				SWR_DATA: if (i_wvalid) state <= SWR_MEM;
				SWR_MEM:  if (i_mem_grant) state <= SWR_RESP;
				SWR_RESP: if (i_bready) state <= SWR_IDLE;
				default:  state <= SWR_IDLE;
			endcase
		end
	end

	// single beat only, wlast is implied
	always_ff @(posedge i_clk) begin
		if (state == SWR_IDLE && i_awvalid)
			word <= i_aw.awaddr[AW+1:2];
		if (state == SWR_DATA && i_wvalid) begin
			wdata <= i_w.wdata;
			wstrb <= i_w.wstrb;
		end
	end

	assign o_awready = (state == SWR_IDLE);
	assign o_wready  = (state == SWR_DATA);
	assign o_bvalid  = (state == SWR_RESP);
	// OKAY
	assign o_b.bresp = 2'b00;

	assign o_mem_req_valid = (state == SWR_MEM);
	assign o_mem_req.addr  = 32'(word);
	assign o_mem_req.we    = 1'b1;
	assign o_mem_req.be    = wstrb;
	assign o_mem_req.wdata = wdata;

endmodule

// File: hw/axi_sram/sram_port_arbiter.sv
`timescale 1ns/10ps
// ==================================================
// round-robin arbiter for the single SRAM port
// read engine vs write engine, one-cycle grants
// ==================================================
module sram_port_arbiter
	import a23_bus_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_arst_n,
	input  mem_req_t i_rd_req,
	input  logic     i_rd_valid,
	input  mem_req_t i_wr_req,
	input  logic     i_wr_valid,
	output logic     o_rd_grant,
	output logic     o_wr_grant,
	output mem_req_t o_mem_req,
	output logic     o_mem_en
);
	// high when the read engine had the last grant
	logic last_rd;

	// lone requester wins at once, a tie goes to the other side
	assign o_rd_grant = i_rd_valid & (~i_wr_valid | ~last_rd);
	assign o_wr_grant = i_wr_valid & (~i_rd_valid | last_rd);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			last_rd <= 1'b0;
		end else if (o_rd_grant) begin
			last_rd <= 1'b1;
		end else if (o_wr_grant) begin
			last_rd <= 1'b0;
		end
	end

	// winner goes to the memory port
	assign o_mem_en  = o_rd_grant | o_wr_grant;
	assign o_mem_req = o_rd_grant ? i_rd_req : i_wr_req;

endmodule

// File: hw/axi_sram/sram_mem.sv
`timescale 1ns/10ps
// ==================================================
// single-port word SRAM
// byte enables, registered read data
// ==================================================
module sram_mem
	import a23_bus_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  logic        i_clk,
	input  mem_req_t    i_mem_req,
	input  logic        i_mem_en,
	output logic [31:0] o_rdata
);
	localparam int AW = $clog2(MEM_WORDS);

	logic [31:0]   mem [MEM_WORDS];
	logic [AW-1:0] idx;

	// upper address bits alias
	assign idx = i_mem_req.addr[AW-1:0];

	always_ff @(posedge i_clk) begin
		if (i_mem_en) begin
			if (i_mem_req.we) begin
				for (int b = 0; b < 4; b++) begin
					if (i_mem_req.be[b])
						mem[idx][8*b +: 8] <= i_mem_req.wdata[8*b +: 8];
				end
			end else begin
				o_rdata <= mem[idx];
			end
		end
	end

endmodule

// File: hw/a23_bus_top.sv
`timescale 1ns/10ps
// ==================================================
// bus interface unit top level
// AXI4 master, SRAM read/write engines,
// port arbiter and memory
// ==================================================
module a23_bus_top
	import a23_bus_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_select,
	input  logic        i_cache_req,
	input  logic        i_write_enable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_write_data,
	input  logic [3:0]  i_byte_enable,
	output logic        o_stall,
	output logic        o_stall_cache,
	output logic [31:0] o_read_data,
	output logic        o_read_valid
);
	// ==================================================
	// AXI channels
	// ==================================================
	axi_ar_t ar;
	logic    arvalid;
	logic    arready;
	axi_r_t  r;
	logic    rvalid;
	logic    rready;
	axi_aw_t aw;
	logic    awvalid;
	logic    awready;
	axi_w_t  w;
	logic    wvalid;
	logic    wready;
	axi_b_t  b;
	logic    bvalid;
	logic    bready;

	// memory port side
	mem_req_t    rd_req;
	logic        rd_req_valid;
	logic        rd_grant;
	mem_req_t    wr_req;
	logic        wr_req_valid;
	logic        wr_grant;
	mem_req_t    mem_req;
	logic        mem_en;
	logic [31:0] mem_rdata;

	a23_axi_master u_master (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_select       (i_select),
		.i_cache_req    (i_cache_req),
		.i_write_enable (i_write_enable),
		.i_address      (i_address),
		.i_write_data   (i_write_data),
		.i_byte_enable  (i_byte_enable),
		.o_stall        (o_stall),
		.o_stall_cache  (o_stall_cache),
		.o_read_data    (o_read_data),
		.o_read_valid   (o_read_valid),
		.o_ar           (ar),
		.o_arvalid      (arvalid),
		.i_arready      (arready),
		.i_r            (r),
		.i_rvalid       (rvalid),
		.o_rready       (rready),
		.o_aw           (aw),
		.o_awvalid      (awvalid),
		.i_awready      (awready),
		.o_w            (w),
		.o_wvalid       (wvalid),
		.i_wready       (wready),
		.i_b            (b),
		.i_bvalid       (bvalid),
		.o_bready       (bready)
	);

	axi_sram_rd #(.MEM_WORDS(MEM_WORDS)) u_sram_rd (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_ar            (ar),
		.i_arvalid       (arvalid),
		.o_arready       (arready),
		.o_r             (r),
		.o_rvalid        (rvalid),
		.i_rready        (rready),
		.o_mem_req       (rd_req),
		.o_mem_req_valid (rd_req_valid),
		.i_mem_grant     (rd_grant),
		.i_mem_rdata     (mem_rdata)
	);

	axi_sram_wr #(.MEM_WORDS(MEM_WORDS)) u_sram_wr (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_aw            (aw),
		.i_awvalid       (awvalid),
		.o_awready       (awready),
		.i_w             (w),
		.i_wvalid        (wvalid),
		.o_wready        (wready),
		.o_b             (b),
		.o_bvalid        (bvalid),
		.i_bready        (bready),
		.o_mem_req       (wr_req),
		.o_mem_req_valid (wr_req_valid),
		.i_mem_grant     (wr_grant)
	);

	sram_port_arbiter u_arbiter (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_rd_req   (rd_req),
		.i_rd_valid (rd_req_valid),
		.i_wr_req   (wr_req),
		.i_wr_valid (wr_req_valid),
		.o_rd_grant (rd_grant),
		.o_wr_grant (wr_grant),
		.o_mem_req  (mem_req),
		.o_mem_en   (mem_en)
	);

	sram_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
		.i_clk     (i_clk),
		.i_mem_req (mem_req),
		.i_mem_en  (mem_en),
		.o_rdata   (mem_rdata)
	);

endmodule

// File: verification/a23_bus_chk.sv
`timescale 1ns/10ps
// ==================================================
// AXI protocol assertions on the bus master
// AR and AW held stable until ready
// single W beats, read data only in read states
// ==================================================
module a23_bus_chk
	import a23_bus_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  axi_ar_t   i_ar,
	input  logic      i_arvalid,
	input  logic      i_arready,
	input  axi_aw_t   i_aw,
	input  logic      i_awvalid,
	input  logic      i_awready,
	input  axi_w_t    i_w,
	input  logic      i_wvalid,
	input  logic      i_read_valid,
	input  rd_state_e i_rd_state
);
	// failed assertion count
	int fail_count = 0;

	// address channels hold until accepted
	a_ar_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_arvalid && !i_arready |=> i_arvalid && $stable(i_ar))
		else begin
			fail_count++;
			$error("AR valid dropped or payload changed before ready");
		end

	a_aw_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_aw))
		else begin
			fail_count++;
			$error("AW valid dropped or payload changed before ready");
		end

	// all writes are one beat
	a_w_last: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_wvalid |-> i_w.wlast)
		else begin
			fail_count++;
			$error("W beat without wlast");
		end

	a_rv_state: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_read_valid |-> (i_rd_state == RD_CORE_R || i_rd_state == RD_LINE_R))
		else begin
			fail_count++;
			$error("read valid outside a read state");
		end

endmodule

// File: verification/a23_bus_tb.sv
`timescale 1ns/10ps
// ==================================================
// testbench for the bus interface unit
// clock, reset, directed and LCG random stimulus
// reference memory model, read data compare
// ==================================================
module a23_bus_tb;

	localparam int MEM_WORDS = 256;
	localparam int IDX_MSB   = $clog2(MEM_WORDS) + 1;
	localparam int TIMEOUT   = 200;

	logic        i_clk;
	logic        i_arst_n;
	logic        i_select;
	logic        i_cache_req;
	logic        i_write_enable;
	logic [31:0] i_address;
	logic [31:0] i_write_data;
	logic [3:0]  i_byte_enable;
	logic        o_stall;
	logic        o_stall_cache;
	logic [31:0] o_read_data;
	logic        o_read_valid;

	// reference memory and words still owed by the DUT
	logic [31:0] model [MEM_WORDS];
	logic [31:0] exp_q [$];
	logic [31:0] seed;
	logic        hung;
	int          rv_count;
	int          err_count;
	int          test_errs;
	int          test_num;
	int          failed_tests;
	// stalled cycles of the last request before it completed
	int          stall_cycles;
	string       test_name;

	a23_bus_top #(.MEM_WORDS(MEM_WORDS)) dut (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_select       (i_select),
		.i_cache_req    (i_cache_req),
		.i_write_enable (i_write_enable),
		.i_address      (i_address),
		.i_write_data   (i_write_data),
		.i_byte_enable  (i_byte_enable),
		.o_stall        (o_stall),
		.o_stall_cache  (o_stall_cache),
		.o_read_data    (o_read_data),
		.o_read_valid   (o_read_valid)
	);

	bind a23_axi_master a23_bus_chk u_chk (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_ar         (o_ar),
		.i_arvalid    (o_arvalid),
		.i_arready    (i_arready),
		.i_aw         (o_aw),
		.i_awvalid    (o_awvalid),
		.i_awready    (i_awready),
		.i_w          (o_w),
		.i_wvalid     (o_wvalid),
		.i_read_valid (o_read_valid),
		.i_rd_state   (rd_state)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// ==================================================
	// reference model
	// ==================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// initial contents, every address bit matters
	function automatic logic [31:0] fill_pattern(input int w);
		return (32'(w) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
	endfunction

	function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] be);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return model[addr[IDX_MSB:2]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s = %08h, expected %08h", $time, name, got, exp);
			err_count++;
			test_errs++;
		end
	endtask

	// every returned word against the head of the queue
	always @(negedge i_clk) begin
		if (i_arst_n && o_read_valid) begin
			rv_count++;
			if (exp_q.size() == 0) begin
				$display("read data pulse at %0d ns with no read outstanding", $time);
				err_count++;
				test_errs++;
			end else begin
				check_value("o_read_data", o_read_data, exp_q.pop_front());
			end
		end
	end

	// ==================================================
	// request drivers, entered and left on a rising edge
	// ==================================================
	task automatic wait_done(input logic cache, input int beats);
		int  cycles;
		int  start_count;
		logic done;
		start_count = rv_count;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TIMEOUT) begin
			@(negedge i_clk);
			if (!(cache ? o_stall_cache : o_stall))
				done = 1'b1;
			else
				cycles++;
		end
		stall_cycles = cycles;
		if (!done) begin
			$display("stall stayed high for %0d cycles at %0d ns, rest skipped", TIMEOUT, $time);
			hung = 1'b1;
			err_count++;
			test_errs++;
		end else begin
			// the last word comes in the completing cycle
			if (beats > 0)
				check_value("o_read_valid", {31'd0, o_read_valid}, 32'd1);
			@(posedge i_clk);
			check_value("read pulse count", rv_count - start_count, beats);
		end
	endtask

	task automatic issue(input logic cache, input logic we, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] be, input int beats);
		if (!hung) begin
			i_select       <= !cache;
			i_cache_req    <= cache;
			i_write_enable <= we;
			i_address      <= addr;
			i_write_data   <= data;
			i_byte_enable  <= be;
			wait_done(cache, beats);
		end
	endtask

	task automatic core_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		issue(1'b0, 1'b1, addr, data, be, 0);
		model[addr[IDX_MSB:2]] = byte_merge(model[addr[IDX_MSB:2]], data, be);
	endtask

	// byte enables are driven low, a write-back stores the full word
	task automatic cache_writeback(input logic [31:0] addr, input logic [31:0] data);
		issue(1'b1, 1'b1, addr, data, 4'h0, 0);
		model[addr[IDX_MSB:2]] = data;
	endtask

	task automatic core_read(input logic [31:0] addr);
		exp_q.push_back(expected_word(addr));
		issue(1'b0, 1'b0, addr, 32'h0, 4'h0, 1);
	endtask

	// wrap order from the requested word through the line
	task automatic cache_fill(input logic [31:0] addr);
		logic [1:0] off;
		for (int k = 0; k < 4; k++) begin
			off = addr[3:2] + 2'(k);
			exp_q.push_back(expected_word({addr[31:4], off, 2'b00}));
		end
		issue(1'b1, 1'b0, addr, 32'h0, 4'h0, 4);
	endtask

	task automatic go_idle();
		i_select       <= 1'b0;
		i_cache_req    <= 1'b0;
		i_write_enable <= 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		test_num++;
	endtask

	task automatic finish_test();
		check_value("words still expected", exp_q.size(), 32'd0);
		if (test_errs == 0) begin
			$display("test %0d %s: pass", test_num, test_name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, test_name, test_errs);
			failed_tests++;
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [2:0]  op;
		logic [3:0]  be;
		i_arst_n       = 1'b0;
		i_select       = 1'b0;
		i_cache_req    = 1'b0;
		i_write_enable = 1'b0;
		i_address      = 32'h0;
		i_write_data   = 32'h0;
		i_byte_enable  = 4'h0;
		seed           = 32'd24;
		hung           = 1'b0;
		rv_count       = 0;
		err_count      = 0;
		test_num       = 0;
		failed_tests   = 0;
		stall_cycles   = 0;
		repeat (2) @(posedge i_clk);
		i_arst_n <= 1'b1;
		@(posedge i_clk);

		start_test("single core read");
		for (int w = 0; w < MEM_WORDS; w++)
			core_write(32'(w) << 2, fill_pattern(w), 4'hf);
		core_read(32'h0000_0084);
		finish_test();

		// each read hits the still buffered write
		start_test("partial byte writes");
		core_write(32'h0000_0010, 32'hdead_beef, 4'b0101);
		core_read(32'h0000_0010);
		core_write(32'h0000_0010, 32'h1234_5678, 4'b1000);
		core_read(32'h0000_0010);
		core_write(32'h0000_0010, 32'hcafe_f00d, 4'b0010);
		core_read(32'h0000_0010);
		finish_test();

		start_test("wrap fills");
		for (int k = 0; k < 4; k++)
			cache_fill(32'h0000_0100 + 32'(k * 4));
		finish_test();

		start_test("write-back then read");
		cache_writeback(32'h0000_02c4, 32'h8765_4321);
		core_read(32'h0000_02c4);
		finish_test();

		// second read overtakes the posted write
		start_test("posted write bypass");
		core_write(32'h0000_0040, 32'ha5a5_5a5a, 4'hf);
		// the buffer is empty here, so the write is taken in its first cycle
		check_value("o_stall cycles on write", stall_cycles, 32'd0);
		core_read(32'h0000_0200);
		core_read(32'h0000_0040);
		finish_test();

		start_test("random operations");
		for (int n = 0; n < 200; n++) begin
			seed = lcg_next(seed);
			op   = seed[31:29];
			seed = lcg_next(seed);
			addr = {22'd0, seed[31:24], 2'b00};
			seed = lcg_next(seed);
			data = seed;
			be   = seed[19:16];
			case (op)
				3'd0, 3'd1, 3'd7: core_read(addr);
				3'd2, 3'd3:       core_write(addr, data, be);
				3'd4, 3'd5:       cache_fill(addr);
				default:          cache_writeback(addr, data);
			endcase
		end
		finish_test();

		go_idle();
		repeat (4) @(posedge i_clk);
		err_count += dut.u_master.u_chk.fail_count;
		$display("tests %0d, failed tests %0d, errors %0d", test_num, failed_tests, err_count);
		if (err_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
common/a23_bus_pkg.sv
hw/axi_master/a23_axi_master.sv
hw/axi_sram/axi_sram_rd.sv
hw/axi_sram/axi_sram_wr.sv
hw/axi_sram/sram_port_arbiter.sv
hw/axi_sram/sram_mem.sv
hw/a23_bus_top.sv
verification/a23_bus_chk.sv
verification/a23_bus_tb.sv

// File: Makefile
# Verilator build and run of the a23 bus testbench

TOP = a23_bus_tb
OBJ = obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): all.f $(wildcard common/*.sv hw/*.sv hw/*/*.sv verification/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f all.f

run: $(OBJ)/V$(TOP)
	-$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf $(OBJ) sim.log
